// File: project.f
+incdir+sim
src/imgGeomPkg.sv
src/imgCtrlPkg.sv
src/addrSequencer.sv
src/pixelRam.sv
src/smoothBranch.sv
src/edgeBranch.sv
src/branchMerge.sv
src/imgFilterTop.sv
sim/imgFilterTb.sv

// File: sim/filterModel.svh
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// 32-bit xorshift step with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// (x[a-2] + 2x[a-1] + x[a]) / 4, truncated
function automatic int smoothRef(input int xm2, input int xm1, input int x0);
    return (xm2 + 2 * xm1 + x0) / 4;
endfunction

// |x[a] - x[a-2]|
function automatic int edgeRef(input int xm2, input int x0);
    return (x0 > xm2) ? (x0 - xm2) : (xm2 - x0);
endfunction

function automatic int filterRef(input imgCtrlPkg::filterOp_t op,
                                 input int xm2, input int xm1, input int x0);
    int sum;
    sum = smoothRef(xm2, xm1, x0) + edgeRef(xm2, x0);
    case (op)
        imgCtrlPkg::OP_BYPASS:  return x0;
        imgCtrlPkg::OP_SMOOTH:  return smoothRef(xm2, xm1, x0);
        imgCtrlPkg::OP_EDGE:    return edgeRef(xm2, x0);
        // Sharpen clips at full scale
        default:                return (sum > 255) ? 255 : sum;
    endcase
endfunction

`endif

// File: sim/imgFilterTb.sv
`timescale 1ns/1ps

module imgFilterTb;

    `include "filterModel.svh"

    localparam int BLOCK_LEN    = 2 ** imgGeomPkg::ADDR_W;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_LOADS    = 5;
    // Accepted start pulse to o_EoP with room for the drain
    localparam int PROC_BOUND   = BLOCK_LEN + 4 * imgGeomPkg::PROC_LATENCY;
    localparam int CYCLE_LIMIT  = NUM_LOADS * (2 * BLOCK_LEN + imgGeomPkg::PROC_LATENCY) + 3700;

    logic i_CLK = 1'b0;
    logic i_reset;
    logic i_SoP;
    logic i_valid;
    logic [imgGeomPkg::PIX_W-1:0] i_pixel;
    imgCtrlPkg::filterOp_t i_op;
    logic [imgGeomPkg::PIX_W-1:0] o_pixel;
    logic o_pixelValid;
    logic o_EoP;
    logic o_changeBlock;

    logic [imgGeomPkg::PIX_W-1:0] blockMem [0:BLOCK_LEN-1];
    logic [imgGeomPkg::PIX_W-1:0] expBlock [0:BLOCK_LEN-1];
    bit clipBlock [0:BLOCK_LEN-1];
    logic [31:0] rngState;
    int reqAddr;
    bit unloadCheck;
    bit started;
    bit inProcess;
    int procCycles;
    int cycleCount = 0;
    int clipCount = 0;
    int pixelErrors = 0;
    int flagErrors = 0;
    int procErrors = 0;

    // Expected outputs registered like the unload path
    logic expValid;
    logic expCheck;
    logic expChange;
    logic expClip;
    logic [imgGeomPkg::PIX_W-1:0] expPixel;

    imgFilterTop i_dut (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_SoP         (i_SoP),
        .i_valid       (i_valid),
        .i_pixel       (i_pixel),
        .i_op          (i_op),
        .o_pixel       (o_pixel),
        .o_pixelValid  (o_pixelValid),
        .o_EoP         (o_EoP),
        .o_changeBlock (o_changeBlock)
    );

    always #20 i_CLK = ~i_CLK;

    always @(posedge i_CLK) begin
        if (i_reset) begin
            expValid  <= 1'b0;
            expCheck  <= 1'b0;
            expChange <= 1'b0;
            expClip   <= 1'b0;
            expPixel  <= '0;
        end else begin
            expValid  <= i_valid;
            expCheck  <= i_valid && unloadCheck;
            expChange <= i_valid && (reqAddr == BLOCK_LEN - 1);
            expClip   <= i_valid && unloadCheck && clipBlock[reqAddr];
            expPixel  <= expBlock[reqAddr];
            // Saturated sharpen results that reached the output
            if (expClip && (o_pixel == 8'd255)) begin
                clipCount <= clipCount + 1;
            end
        end
        procCycles <= inProcess ? procCycles + 1 : 0;
    end

    always @(posedge i_CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Quiet outputs between reset and the first load
    assert property (@(posedge i_CLK) disable iff (i_reset)
        !started |-> !(o_EoP || o_changeBlock || o_pixelValid))
        else begin
            flagErrors++;
            $display("** Error at %0t: o_EoP/o_changeBlock/o_pixelValid expected 000, got %b%b%b",
                     $time, $sampled(o_EoP), $sampled(o_changeBlock), $sampled(o_pixelValid));
        end

    assert property (@(posedge i_CLK) disable iff (i_reset) o_pixelValid == expValid)
        else begin
            flagErrors++;
            $display("** Error at %0t: o_pixelValid expected %b, got %b",
                     $time, $sampled(expValid), $sampled(o_pixelValid));
        end

    // One pulse after the last address of a load and never elsewhere
    assert property (@(posedge i_CLK) disable iff (i_reset) o_changeBlock == expChange)
        else begin
            flagErrors++;
            $display("** Error at %0t: o_changeBlock expected %b, got %b",
                     $time, $sampled(expChange), $sampled(o_changeBlock));
        end

    assert property (@(posedge i_CLK) disable iff (i_reset) expCheck |-> (o_pixel == expPixel))
        else begin
            pixelErrors++;
            $display("** Error at %0t: o_pixel expected %0d, got %0d",
                     $time, $sampled(expPixel), $sampled(o_pixel));
        end

    assert property (@(posedge i_CLK) disable iff (i_reset) i_SoP |=> !o_EoP)
        else begin
            procErrors++;
            $display("** Error at %0t: o_EoP expected 0, got 1", $time);
        end

    assert property (@(posedge i_CLK) disable iff (i_reset) (o_EoP && !i_SoP) |=> o_EoP)
        else begin
            procErrors++;
            $display("o_EoP fell at %0t without a start pulse", $time);
        end

    assert property (@(posedge i_CLK) disable iff (i_reset)
        o_EoP |-> (i_dut.u_seq.state == imgCtrlPkg::ST_IDLE))
        else begin
            procErrors++;
            $display("o_EoP was high at %0t while the sequencer was not idle", $time);
        end

    // A restart on the stray pulse would push o_EoP past this bound
    assert property (@(posedge i_CLK) disable iff (i_reset) inProcess |-> procCycles <= PROC_BOUND)
        else begin
            procErrors++;
            $display("Processing ran past %0d cycles at %0t", PROC_BOUND, $time);
        end

    task automatic loadBlock(input bit satBlock, input bit checkUnload);
        int a;
        for (a = 0; a < BLOCK_LEN; a++) begin
            @(negedge i_CLK);
            rngState = xorshift32(rngState);
            i_pixel = rngState[imgGeomPkg::PIX_W-1:0];
            // Pattern 0, 255, 255, random drives the sharpen sum past full scale
            if (satBlock && (a % 4 == 0)) i_pixel = 8'd0;
            if (satBlock && (a % 4 == 1 || a % 4 == 2)) i_pixel = 8'd255;
            i_valid = 1'b1;
            blockMem[a] = i_pixel;
            reqAddr = a;
            unloadCheck = checkUnload;
        end
        @(negedge i_CLK);
        i_valid = 1'b0;
    endtask

    task automatic computeExpected(input imgCtrlPkg::filterOp_t op);
        int a;
        int xm2;
        int xm1;
        for (a = 0; a < BLOCK_LEN; a++) begin
            // Zero history before the first sample of a block
            xm2 = (a >= 2) ? blockMem[a-2] : 0;
            xm1 = (a >= 1) ? blockMem[a-1] : 0;
            expBlock[a] = filterRef(op, xm2, xm1, blockMem[a]);
            clipBlock[a] = (op == imgCtrlPkg::OP_SHARPEN) &&
                (smoothRef(xm2, xm1, blockMem[a]) + edgeRef(xm2, blockMem[a]) > 255);
        end
    endtask

    task automatic runBlock(input imgCtrlPkg::filterOp_t op, input bit straySoP);
        computeExpected(op);
        @(negedge i_CLK);
        i_op = op;
        i_SoP = 1'b1;
        inProcess = 1'b1;
        @(negedge i_CLK);
        i_SoP = 1'b0;
        if (straySoP) begin
            repeat (300) @(negedge i_CLK);
            i_SoP = 1'b1;
            @(negedge i_CLK);
            i_SoP = 1'b0;
        end
        while (!o_EoP) @(negedge i_CLK);
        inProcess = 1'b0;
    endtask

    initial begin
        i_reset = 1'b1;
        i_SoP = 1'b0;
        i_valid = 1'b0;
        i_pixel = '0;
        i_op = imgCtrlPkg::OP_BYPASS;
        rngState = 32'hb513f395;
        reqAddr = 0;
        unloadCheck = 1'b0;
        started = 1'b0;
        inProcess = 1'b0;
        procCycles = 0;
        repeat (RESET_CYCLES) @(negedge i_CLK);
        i_reset = 1'b0;
        repeat (4) @(negedge i_CLK);
        started = 1'b1;

        // Each block is unloaded while the next one loads
        loadBlock(1'b0, 1'b0);
        runBlock(imgCtrlPkg::OP_BYPASS, 1'b0);
        loadBlock(1'b0, 1'b1);
        runBlock(imgCtrlPkg::OP_SMOOTH, 1'b1);
        loadBlock(1'b0, 1'b1);
        runBlock(imgCtrlPkg::OP_EDGE, 1'b0);
        loadBlock(1'b1, 1'b1);
        runBlock(imgCtrlPkg::OP_SHARPEN, 1'b0);
        loadBlock(1'b0, 1'b1);
        repeat (4) @(negedge i_CLK);

        assert (clipCount > 0)
            else begin
                pixelErrors++;
                $display("No saturated sharpen result was seen at the output");
            end

        $display("Error counts: pixel %0d, flag %0d, process %0d",
                 pixelErrors, flagErrors, procErrors);
        if (pixelErrors + flagErrors + procErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src/addrSequencer.sv
`timescale 1ns/1ps

module addrSequencer (
    input  logic                          i_CLK,
    input  logic                          i_reset,
    input  logic                          i_SoP,
    input  logic                          i_valid,
    output logic [imgGeomPkg::ADDR_W-1:0] o_readAdd,
    output logic [imgGeomPkg::ADDR_W-1:0] o_writeAdd,
    output logic                          o_writeEn,
    output logic                          o_procStart,
    output logic                          o_loadEn,
    output logic                          o_EoP,
    output logic                          o_changeBlock
);

    imgCtrlPkg::seqState_t state;

    logic [imgGeomPkg::ADDR_W-1:0] addrCount;
    // Tap k holds the counter from k cycles ago
    logic [imgGeomPkg::ADDR_W-1:0] addrDly [1:imgGeomPkg::PROC_LATENCY-1];
    logic [imgGeomPkg::PROC_LATENCY-1:1] validDly;
    logic endOfProcess;
    logic changeBlock;
    logic sopAccept;
    logic blockEnd;
    logic drainDone;

    // Start pulse only counts when idle
    assign sopAccept = i_SoP && (state == imgCtrlPkg::ST_IDLE);
    assign blockEnd  = (addrCount == imgGeomPkg::BLOCK_LAST);

    // Last sample in flight is being written and nothing follows it
    assign drainDone = validDly[imgGeomPkg::PROC_LATENCY-1] &&
                       (validDly[imgGeomPkg::PROC_LATENCY-2:1] == '0);

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state        <= imgCtrlPkg::ST_IDLE;
            addrCount    <= '0;
            endOfProcess <= 1'b0;
            changeBlock  <= 1'b0;
        end else begin
            changeBlock <= 1'b0;
            case (state)
                imgCtrlPkg::ST_IDLE: begin
                    if (sopAccept) begin
                        state        <= imgCtrlPkg::ST_PROCESS;
                        addrCount    <= '0;
                        endOfProcess <= 1'b0;
                    end else if (i_valid) begin
                        // Load and unload share the counter
                        if (blockEnd) begin
                            addrCount   <= '0;
                            changeBlock <= 1'b1;
                        end else begin
                            addrCount <= addrCount + 1'b1;
                        end
                    end
                end
                imgCtrlPkg::ST_PROCESS: begin
                    if (blockEnd) begin
                        addrCount <= '0;
                        state     <= imgCtrlPkg::ST_DRAIN;
                    end else begin
                        addrCount <= addrCount + 1'b1;
                    end
                end
                imgCtrlPkg::ST_DRAIN: begin
                    if (drainDone) begin
                        state        <= imgCtrlPkg::ST_IDLE;
                        endOfProcess <= 1'b1;
                    end
                end
                default: begin
                    state <= imgCtrlPkg::ST_IDLE;
                end
            endcase
        end
    end

    // The write edge itself is the last step of the address delay line
    always_ff @(posedge i_CLK) begin
        addrDly[1] <= addrCount;
        for (int k = 2; k < imgGeomPkg::PROC_LATENCY; k++) begin
            addrDly[k] <= addrDly[k-1];
        end
    end

    // Valid delay line marks which taps carry a processed sample
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            validDly <= '0;
        end else begin
            validDly <= {validDly[imgGeomPkg::PROC_LATENCY-2:1],
                         state == imgCtrlPkg::ST_PROCESS};
        end
    end

    assign o_readAdd     = addrCount;
    assign o_writeAdd    = (state == imgCtrlPkg::ST_IDLE) ?
                           addrCount : addrDly[imgGeomPkg::PROC_LATENCY-1];
    assign o_writeEn     = validDly[imgGeomPkg::PROC_LATENCY-1];
    // High in the first processing cycle to line up with the first memory read
    assign o_procStart   = (state == imgCtrlPkg::ST_PROCESS) && (addrCount == '0);
    assign o_loadEn      = i_valid && (state == imgCtrlPkg::ST_IDLE);
    assign o_EoP         = endOfProcess;
    assign o_changeBlock = changeBlock;

    // Block change only follows a full load with the processing pipeline empty
    assert property (@(posedge i_CLK) disable iff (i_reset)
        $rose(o_changeBlock) |-> (state == imgCtrlPkg::ST_IDLE) && (validDly == '0))
        else $error("changeBlock rose outside of load/unload");

    // Pipeline writes are finished before returning to idle
    assert property (@(posedge i_CLK) disable iff (i_reset)
        (state == imgCtrlPkg::ST_IDLE) |-> !o_writeEn)
        else $error("processing write enable active while idle");

endmodule

// File: src/branchMerge.sv
`timescale 1ns/1ps

module branchMerge (
    input  logic                         i_CLK,
    input  logic                         i_reset,
    input  imgCtrlPkg::filterOp_t        i_op,
    input  logic [imgGeomPkg::PIX_W-1:0] i_smooth,
    input  logic [imgGeomPkg::PIX_W-1:0] i_edge,
    input  logic [imgGeomPkg::PIX_W-1:0] i_raw,
    output logic [imgGeomPkg::PIX_W-1:0] o_result
);

    // One carry bit for the sharpen sum
    logic [imgGeomPkg::PIX_W:0] sharpSum;
    logic [imgGeomPkg::PIX_W-1:0] nextResult;
    logic [imgGeomPkg::PIX_W-1:0] resultReg;

    always_comb begin
        sharpSum = {1'b0, i_smooth} + {1'b0, i_edge};
        case (i_op)
            imgCtrlPkg::OP_BYPASS: begin
                nextResult = i_raw;
            end
            imgCtrlPkg::OP_SMOOTH: begin
                nextResult = i_smooth;
            end
            imgCtrlPkg::OP_EDGE: begin
                nextResult = i_edge;
            end
            imgCtrlPkg::OP_SHARPEN: begin
                // Clip at 255 on carry out
                if (sharpSum[imgGeomPkg::PIX_W]) begin
                    nextResult = '1;
                end else begin
                    nextResult = sharpSum[imgGeomPkg::PIX_W-1:0];
                end
            end
            default: begin
                nextResult = i_raw;
            end
        endcase
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            resultReg <= '0;
        end else begin
            resultReg <= nextResult;
        end
    end

    assign o_result = resultReg;

    // Opcode comes straight from the host pins
    assert property (@(posedge i_CLK) disable iff (i_reset) !$isunknown(i_op))
        else $error("filter opcode is unknown");

endmodule

// File: src/edgeBranch.sv
`timescale 1ns/1ps

module edgeBranch (
    input  logic                         i_CLK,
    input  logic                         i_reset,
    input  logic                         i_clear,
    input  logic [imgGeomPkg::PIX_W-1:0] i_sample,
    output logic [imgGeomPkg::PIX_W-1:0] o_edge
);

    logic [imgGeomPkg::PIX_W-1:0] tapNear;
    logic [imgGeomPkg::PIX_W-1:0] tapFar;
    logic signed [imgGeomPkg::EDGE_DIFF_W-1:0] diffReg;
    logic [imgGeomPkg::EDGE_DIFF_W-1:0] diffMag;
    logic [imgGeomPkg::PIX_W-1:0] edgeReg;

    // Own copy of the window, cleared with the smoothing taps
    always_ff @(posedge i_CLK) begin
        if (i_reset || i_clear) begin
            tapNear <= '0;
            tapFar  <= '0;
        end else begin
            tapNear <= i_sample;
            tapFar  <= tapNear;
        end
    end

    // Stage 1: newest minus oldest
    always_ff @(posedge i_CLK) begin
        diffReg <= $signed({1'b0, i_sample}) - $signed({1'b0, tapFar});
    end

    // Magnitude fits back into a pixel
    always_comb begin
        diffMag = diffReg[imgGeomPkg::EDGE_DIFF_W-1] ? -diffReg : diffReg;
    end

    // Stage 2
    always_ff @(posedge i_CLK) begin
        edgeReg <= diffMag[imgGeomPkg::PIX_W-1:0];
    end

    assign o_edge = edgeReg;

endmodule

// File: src/imgCtrlPkg.sv
package imgCtrlPkg;

    // Sequencer states
    typedef enum logic [1:0] {
        // Load next block and unload previous results
        ST_IDLE    = 2'd0,
        // Reading the input memory, one address per cycle
        ST_PROCESS = 2'd1,
        // Waiting for the last writes to leave the pipeline
        ST_DRAIN   = 2'd2
    } seqState_t;

    // Filter opcodes, held constant from start pulse to end of process
    typedef enum logic [1:0] {
        // Raw sample
        OP_BYPASS  = 2'd0,
        // 1-2-1 smoothing
        OP_SMOOTH  = 2'd1,
        // Absolute difference over the window
        OP_EDGE    = 2'd2,
        // smooth plus edge, clipped at full scale
        OP_SHARPEN = 2'd3
    } filterOp_t;

endpackage

// File: src/imgFilterTop.sv
`timescale 1ns/1ps

module imgFilterTop (
    input  logic                         i_CLK,
    input  logic                         i_reset,
    input  logic                         i_SoP,
    input  logic                         i_valid,
    input  logic [imgGeomPkg::PIX_W-1:0] i_pixel,
    input  imgCtrlPkg::filterOp_t        i_op,
    output logic [imgGeomPkg::PIX_W-1:0] o_pixel,
    output logic                         o_pixelValid,
    output logic                         o_EoP,
    output logic                         o_changeBlock
);

    logic [imgGeomPkg::ADDR_W-1:0] readAdd;
    logic [imgGeomPkg::ADDR_W-1:0] writeAdd;
    logic [imgGeomPkg::ADDR_W-1:0] inReadAdd;
    logic writeEn;
    logic procStart;
    logic loadEn;
    logic [imgGeomPkg::PIX_W-1:0] inSample;
    logic [imgGeomPkg::PIX_W-1:0] smoothVal;
    logic [imgGeomPkg::PIX_W-1:0] rawVal;
    logic [imgGeomPkg::PIX_W-1:0] edgeVal;
    logic [imgGeomPkg::PIX_W-1:0] mergeVal;
    logic pixelValid;

    addrSequencer u_seq (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_SoP         (i_SoP),
        .i_valid       (i_valid),
        .o_readAdd     (readAdd),
        .o_writeAdd    (writeAdd),
        .o_writeEn     (writeEn),
        .o_procStart   (procStart),
        .o_loadEn      (loadEn),
        .o_EoP         (o_EoP),
        .o_changeBlock (o_changeBlock)
    );

    // Input memory read data is unused while loading
    // so its read port steps off the write address
    assign inReadAdd = loadEn ? readAdd + 1'b1 : readAdd;

    pixelRam inRam (
        .i_CLK       (i_CLK),
        .i_writeEn   (loadEn),
        .i_writeAdd  (writeAdd),
        .i_writeData (i_pixel),
        .i_readAdd   (inReadAdd),
        .o_readData  (inSample)
    );

    smoothBranch u_smooth (
        .i_CLK    (i_CLK),
        .i_reset  (i_reset),
        .i_clear  (procStart),
        .i_sample (inSample),
        .o_smooth (smoothVal),
        .o_raw    (rawVal)
    );

    edgeBranch u_edge (
        .i_CLK    (i_CLK),
        .i_reset  (i_reset),
        .i_clear  (procStart),
        .i_sample (inSample),
        .o_edge   (edgeVal)
    );

    branchMerge u_merge (
        .i_CLK    (i_CLK),
        .i_reset  (i_reset),
        .i_op     (i_op),
        .i_smooth (smoothVal),
        .i_edge   (edgeVal),
        .i_raw    (rawVal),
        .o_result (mergeVal)
    );

    // Results land here, read back during the next load
    pixelRam outRam (
        .i_CLK       (i_CLK),
        .i_writeEn   (writeEn),
        .i_writeAdd  (writeAdd),
        .i_writeData (mergeVal),
        .i_readAdd   (readAdd),
        .o_readData  (o_pixel)
    );

    // Unload data trails the request by the memory read
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= loadEn;
        end
    end

    assign o_pixelValid = pixelValid;

endmodule

// File: src/imgGeomPkg.sv
package imgGeomPkg;

    // Address width of one image block
    localparam int ADDR_W = 10;

    // Pixel width
    localparam int PIX_W = 8;

    // Last address of a block, 1023
    localparam logic [ADDR_W-1:0] BLOCK_LAST = '1;

    // Edges from read address to output memory write:
    // memory read 1, branches 2, merge 1, write 1
    localparam int PROC_LATENCY = 5;

    // 1-2-1 weighted sum needs two guard bits
    localparam int SMOOTH_SUM_W = PIX_W + 2;

    // Signed difference of two pixels
    localparam int EDGE_DIFF_W = PIX_W + 1;

endpackage

// File: src/pixelRam.sv
`timescale 1ns/1ps

module pixelRam (
    input  logic                          i_CLK,
    input  logic                          i_writeEn,
    input  logic [imgGeomPkg::ADDR_W-1:0] i_writeAdd,
    input  logic [imgGeomPkg::PIX_W-1:0]  i_writeData,
    input  logic [imgGeomPkg::ADDR_W-1:0] i_readAdd,
    output logic [imgGeomPkg::PIX_W-1:0]  o_readData
);

    // One block of pixels
    logic [imgGeomPkg::PIX_W-1:0] mem [0:(2**imgGeomPkg::ADDR_W)-1];
    logic [imgGeomPkg::PIX_W-1:0] readData;

    always_ff @(posedge i_CLK) begin
        if (i_writeEn) begin
            mem[i_writeAdd] <= i_writeData;
        end
    end

    // Registered read port
    always_ff @(posedge i_CLK) begin
        readData <= mem[i_readAdd];
    end

    assign o_readData = readData;

    // Sequencer keeps the write address away from the live read address
    assert property (@(posedge i_CLK)
        i_writeEn |-> (i_writeAdd != i_readAdd))
        else $error("read and write collide on address %0d", i_writeAdd);

endmodule

// File: src/smoothBranch.sv
`timescale 1ns/1ps

module smoothBranch (
    input  logic                         i_CLK,
    input  logic                         i_reset,
    input  logic                         i_clear,
    input  logic [imgGeomPkg::PIX_W-1:0] i_sample,
    output logic [imgGeomPkg::PIX_W-1:0] o_smooth,
    output logic [imgGeomPkg::PIX_W-1:0] o_raw
);

    // x[a-1] and x[a-2]
    logic [imgGeomPkg::PIX_W-1:0] tapNear;
    logic [imgGeomPkg::PIX_W-1:0] tapFar;
    logic [imgGeomPkg::SMOOTH_SUM_W-1:0] weightSum;
    logic [imgGeomPkg::PIX_W-1:0] rawDly;
    logic [imgGeomPkg::PIX_W-1:0] smoothReg;
    logic [imgGeomPkg::PIX_W-1:0] rawReg;

    // History starts from zero at every block
    always_ff @(posedge i_CLK) begin
        if (i_reset || i_clear) begin
            tapNear <= '0;
            tapFar  <= '0;
        end else begin
            tapNear <= i_sample;
            tapFar  <= tapNear;
        end
    end

    // Stage 1: weighted sum x[a-2] + 2x[a-1] + x[a]
    always_ff @(posedge i_CLK) begin
        weightSum <= {2'b00, tapFar} + {1'b0, tapNear, 1'b0} + {2'b00, i_sample};
        rawDly    <= i_sample;
    end

    // Stage 2: divide by four, raw sample kept in step
    always_ff @(posedge i_CLK) begin
        smoothReg <= weightSum[imgGeomPkg::SMOOTH_SUM_W-1:2];
        rawReg    <= rawDly;
    end

    assign o_smooth = smoothReg;
    assign o_raw    = rawReg;

endmodule
